//--- valu_defs.svh
`ifndef VALU_DEFS_SVH
`define VALU_DEFS_SVH

// Operand and result width
`define VALU_DW 64

// Byte slices in one operand
`define VALU_NBYTES (`VALU_DW / 8)

// Lane widths selected by ww
`define VALU_LW8 8
`define VALU_LW16 16
`define VALU_LW32 32
`define VALU_LW64 64

// Shift amount bits taken from the low end of each rb lane
`define VALU_SH8_W 3
`define VALU_SH16_W 4
`define VALU_SH32_W 5
`define VALU_SH64_W 6

`endif

//--- valu_pkg.sv
`default_nettype none

`include "valu_defs.svh"

package valu_pkg;

	// Bit 0 is the MSB, lane 0 is the leftmost lane
	typedef logic [0:`VALU_DW-1] dword_t;

	// One bit per byte slice
	typedef logic [0:`VALU_NBYTES-1] lane_carry_t;

	// Function field of an R_ALU instruction
	typedef enum logic [0:5] {
		VNOP   = 6'b000000,
		VAND   = 6'b000001,
		VOR    = 6'b000010,
		VXOR   = 6'b000011,
		VNOT   = 6'b000100,
		VMOV   = 6'b000101,
		VADD   = 6'b000110,
		VSUB   = 6'b000111,
		VMULEU = 6'b001000,
		VMULOU = 6'b001001,
		VSLL   = 6'b001010,
		VSRL   = 6'b001011,
		VSRA   = 6'b001100,
		VRTTH  = 6'b001101
	} func_t;

	typedef enum logic [0:1] {
		W8  = 2'b00,
		W16 = 2'b01,
		W32 = 2'b10,
		W64 = 2'b11
	} width_t;

	typedef enum logic [0:5] {
		R_ALU = 6'b101010
	} major_op_t;

endpackage

`default_nettype wire

//--- valu_bitwise.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_bitwise (
	input  valu_pkg::func_t  func,
	input  valu_pkg::width_t ww,
	input  valu_pkg::dword_t ra,
	input  valu_pkg::dword_t rb,
	output valu_pkg::dword_t res
);

	valu_pkg::dword_t rtth;

	// Swap the two halves of every lane
	always_comb begin
		rtth = '0;
		case (ww)
			valu_pkg::W8: begin
				for (int i = 0; i < `VALU_DW / `VALU_LW8; i++) begin
					rtth[i*`VALU_LW8 +: `VALU_LW8] = {
						ra[i*`VALU_LW8 + `VALU_LW8/2 +: `VALU_LW8/2],
						ra[i*`VALU_LW8 +: `VALU_LW8/2]};
				end
			end
			valu_pkg::W16: begin
				for (int i = 0; i < `VALU_DW / `VALU_LW16; i++) begin
					rtth[i*`VALU_LW16 +: `VALU_LW16] = {
						ra[i*`VALU_LW16 + `VALU_LW16/2 +: `VALU_LW16/2],
						ra[i*`VALU_LW16 +: `VALU_LW16/2]};
				end
			end
			valu_pkg::W32: begin
				for (int i = 0; i < `VALU_DW / `VALU_LW32; i++) begin
					rtth[i*`VALU_LW32 +: `VALU_LW32] = {
						ra[i*`VALU_LW32 + `VALU_LW32/2 +: `VALU_LW32/2],
						ra[i*`VALU_LW32 +: `VALU_LW32/2]};
				end
			end
			default: begin
				rtth = {ra[`VALU_LW64/2 +: `VALU_LW64/2], ra[0 +: `VALU_LW64/2]};
			end
		endcase
	end

	always_comb begin
		case (func)
			valu_pkg::VAND:  res = ra & rb;
			valu_pkg::VOR:   res = ra | rb;
			valu_pkg::VXOR:  res = ra ^ rb;
			valu_pkg::VNOT:  res = ~ra;
			valu_pkg::VMOV:  res = ra;
			valu_pkg::VRTTH: res = rtth;
			default:         res = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- valu_addsub.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_addsub (
	input  logic             sub,
	input  valu_pkg::width_t ww,
	input  valu_pkg::dword_t ra,
	input  valu_pkg::dword_t rb,
	output valu_pkg::dword_t res
);

	valu_pkg::lane_carry_t cut;
	valu_pkg::dword_t      b_in;

	// Lowest byte of each lane, where the chain is broken
	always_comb begin
		case (ww)
			valu_pkg::W8:  cut = 8'b1111_1111;
			valu_pkg::W16: cut = 8'b0101_0101;
			valu_pkg::W32: cut = 8'b0001_0001;
			default:       cut = 8'b0000_0001;
		endcase
	end

	// Two's complement of rb with the per-lane carry below
	assign b_in = sub ? ~rb : rb;

	// Ripple from the rightmost byte toward byte 0
	always_comb begin
		logic       c;
		logic [8:0] sum;
		c = sub;
		sum = '0;
		res = '0;
		for (int i = `VALU_NBYTES - 1; i >= 0; i--) begin
			if (cut[i]) begin
				c = sub;
			end
			sum = {1'b0, ra[i*`VALU_LW8 +: `VALU_LW8]}
				+ {1'b0, b_in[i*`VALU_LW8 +: `VALU_LW8]}
				+ {8'd0, c};
			res[i*`VALU_LW8 +: `VALU_LW8] = sum[7:0];
			c = sum[8];
		end
	end

endmodule

`default_nettype wire

//--- valu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_shifter (
	input  valu_pkg::func_t  func,
	input  valu_pkg::width_t ww,
	input  valu_pkg::dword_t ra,
	input  valu_pkg::dword_t rb,
	output valu_pkg::dword_t res
);

	logic             left;
	logic             arith;
	valu_pkg::dword_t res_w;

	// Lane sits right aligned, result comes back in the low lw bits
	function automatic logic [63:0] shift_lane(input logic [63:0] lane, input int lw,
			input logic [5:0] amt, input logic sl, input logic sa);
		logic [63:0] ext;
		logic [63:0] r;
		ext = lane;
		if (sa && lane[lw-1]) begin
			ext = lane | (~64'd0 << lw);
		end
		if (sl) begin
			r = ext << amt;
		end else if (sa) begin
			r = $signed(ext) >>> amt;
		end else begin
			r = ext >> amt;
		end
		return r;
	endfunction

	assign left  = (func == valu_pkg::VSLL);
	assign arith = (func == valu_pkg::VSRA);

	always_comb begin
		logic [63:0] tmp;
		tmp = '0;
		res_w = '0;
		case (ww)
			valu_pkg::W8: begin
				for (int i = 0; i < `VALU_DW / `VALU_LW8; i++) begin
					tmp = shift_lane(64'(ra[i*`VALU_LW8 +: `VALU_LW8]), `VALU_LW8,
						6'(rb[(i+1)*`VALU_LW8 - `VALU_SH8_W +: `VALU_SH8_W]), left, arith);
					res_w[i*`VALU_LW8 +: `VALU_LW8] = tmp[`VALU_LW8-1:0];
				end
			end
			valu_pkg::W16: begin
				for (int i = 0; i < `VALU_DW / `VALU_LW16; i++) begin
					tmp = shift_lane(64'(ra[i*`VALU_LW16 +: `VALU_LW16]), `VALU_LW16,
						6'(rb[(i+1)*`VALU_LW16 - `VALU_SH16_W +: `VALU_SH16_W]), left, arith);
					res_w[i*`VALU_LW16 +: `VALU_LW16] = tmp[`VALU_LW16-1:0];
				end
			end
			valu_pkg::W32: begin
				for (int i = 0; i < `VALU_DW / `VALU_LW32; i++) begin
					tmp = shift_lane(64'(ra[i*`VALU_LW32 +: `VALU_LW32]), `VALU_LW32,
						6'(rb[(i+1)*`VALU_LW32 - `VALU_SH32_W +: `VALU_SH32_W]), left, arith);
					res_w[i*`VALU_LW32 +: `VALU_LW32] = tmp[`VALU_LW32-1:0];
				end
			end
			default: begin
				tmp = shift_lane(64'(ra), `VALU_LW64,
					rb[`VALU_LW64 - `VALU_SH64_W +: `VALU_SH64_W], left, arith);
				res_w = tmp;
			end
		endcase
	end

	assign res = (left || arith || func == valu_pkg::VSRL) ? res_w : '0;

endmodule

`default_nettype wire

//--- valu_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_mult (
	input  logic             odd,
	input  valu_pkg::width_t ww,
	input  valu_pkg::dword_t ra,
	input  valu_pkg::dword_t rb,
	output valu_pkg::dword_t res
);

	// Lane 2p or 2p+1 feeds the double-width slot of pair p
	always_comb begin
		int lane;
		lane = 0;
		res = '0;
		case (ww)
			valu_pkg::W8: begin
				for (int p = 0; p < `VALU_DW / (2 * `VALU_LW8); p++) begin
					lane = 2 * p + int'(odd);
					res[p*2*`VALU_LW8 +: 2*`VALU_LW8] =
						16'(ra[lane*`VALU_LW8 +: `VALU_LW8])
						* 16'(rb[lane*`VALU_LW8 +: `VALU_LW8]);
				end
			end
			valu_pkg::W16: begin
				for (int p = 0; p < `VALU_DW / (2 * `VALU_LW16); p++) begin
					lane = 2 * p + int'(odd);
					res[p*2*`VALU_LW16 +: 2*`VALU_LW16] =
						32'(ra[lane*`VALU_LW16 +: `VALU_LW16])
						* 32'(rb[lane*`VALU_LW16 +: `VALU_LW16]);
				end
			end
			valu_pkg::W32: begin
				lane = int'(odd);
				res = 64'(ra[lane*`VALU_LW32 +: `VALU_LW32])
					* 64'(rb[lane*`VALU_LW32 +: `VALU_LW32]);
			end
			// No 64x64 product
			default: begin
				res = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- valu_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module valu_result_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue,
	input  valu_pkg::major_op_t op_code,
	input  valu_pkg::func_t     r_ins,
	input  valu_pkg::dword_t    logic_res,
	input  valu_pkg::dword_t    addsub_res,
	input  valu_pkg::dword_t    shift_res,
	input  valu_pkg::dword_t    mult_res,
	output valu_pkg::dword_t    result,
	output logic                result_valid
);

	valu_pkg::dword_t sel_res;

	// Pick the unit that owns the function
	always_comb begin
		sel_res = '0;
		if (op_code == valu_pkg::R_ALU) begin
			case (r_ins)
				valu_pkg::VAND,
				valu_pkg::VOR,
				valu_pkg::VXOR,
				valu_pkg::VNOT,
				valu_pkg::VMOV,
				valu_pkg::VRTTH: sel_res = logic_res;
				valu_pkg::VADD,
				valu_pkg::VSUB: sel_res = addsub_res;
				valu_pkg::VSLL,
				valu_pkg::VSRL,
				valu_pkg::VSRA: sel_res = shift_res;
				valu_pkg::VMULEU,
				valu_pkg::VMULOU: sel_res = mult_res;
				default: sel_res = '0;
			endcase
		end
	end

	// One cycle from issue to result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result       <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= issue;
			if (issue) begin
				result <= sel_res;
			end
		end
	end

endmodule

`default_nettype wire

//--- valu_top.sv
`timescale 1ns/1ps
`default_nettype none

module valu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue,
	input  valu_pkg::major_op_t op_code,
	input  valu_pkg::func_t     r_ins,
	input  valu_pkg::width_t    ww,
	input  valu_pkg::dword_t    ra,
	input  valu_pkg::dword_t    rb,
	output valu_pkg::dword_t    result,
	output logic                result_valid
);

	logic             sub;
	logic             odd;
	valu_pkg::dword_t logic_res;
	valu_pkg::dword_t addsub_res;
	valu_pkg::dword_t shift_res;
	valu_pkg::dword_t mult_res;

	assign sub = (r_ins == valu_pkg::VSUB);
	assign odd = (r_ins == valu_pkg::VMULOU);

	valu_bitwise u_bitwise (
		.func (r_ins),
		.ww   (ww),
		.ra   (ra),
		.rb   (rb),
		.res  (logic_res)
	);

	valu_addsub u_addsub (
		.sub  (sub),
		.ww   (ww),
		.ra   (ra),
		.rb   (rb),
		.res  (addsub_res)
	);

	valu_shifter u_shifter (
		.func (r_ins),
		.ww   (ww),
		.ra   (ra),
		.rb   (rb),
		.res  (shift_res)
	);

	valu_mult u_mult (
		.odd  (odd),
		.ww   (ww),
		.ra   (ra),
		.rb   (rb),
		.res  (mult_res)
	);

	valu_result_stage u_result_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue),
		.op_code      (op_code),
		.r_ins        (r_ins),
		.logic_res    (logic_res),
		.addsub_res   (addsub_res),
		.shift_res    (shift_res),
		.mult_res     (mult_res),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

`default_nettype wire

//--- valu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module valu_sva (
	input logic             clk,
	input logic             rst_n,
	input logic             issue,
	input valu_pkg::dword_t result,
	input logic             result_valid
);

	// Valid is issue seen one clock later
	valid_after_issue: assert property (
		@(posedge clk) disable iff (!rst_n) result_valid == $past(issue)
	) else $error("result_valid does not follow issue by one cycle");

	no_valid_in_reset: assert property (
		@(posedge clk) !rst_n |-> !result_valid
	) else $error("result_valid high during reset");

	// Without a result the output register holds
	hold_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n) !result_valid |-> $stable(result)
	) else $error("result changed while result_valid was low");

endmodule

bind valu_top valu_sva sva0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.issue        (issue),
	.result       (result),
	.result_valid (result_valid)
);

`default_nettype wire

//--- valu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_tb;

	localparam int VALID_TIMEOUT = 10;

	logic                clk;
	logic                rst_n;
	logic                issue;
	valu_pkg::major_op_t op_code;
	valu_pkg::func_t     r_ins;
	valu_pkg::width_t    ww;
	valu_pkg::dword_t    ra;
	valu_pkg::dword_t    rb;
	valu_pkg::dword_t    result;
	logic                result_valid;

	int    checks;
	int    errors;
	string test_name;

	valu_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue),
		.op_code      (op_code),
		.r_ins        (r_ins),
		.ww           (ww),
		.ra           (ra),
		.rb           (rb),
		.result       (result),
		.result_valid (result_valid)
	);

	always #10 clk = ~clk;

	function automatic int lane_bits(input valu_pkg::width_t w);
		case (w)
			valu_pkg::W8:  return `VALU_LW8;
			valu_pkg::W16: return `VALU_LW16;
			valu_pkg::W32: return `VALU_LW32;
			default:       return `VALU_LW64;
		endcase
	endfunction

	function automatic int amount_bits(input valu_pkg::width_t w);
		case (w)
			valu_pkg::W8:  return `VALU_SH8_W;
			valu_pkg::W16: return `VALU_SH16_W;
			valu_pkg::W32: return `VALU_SH32_W;
			default:       return `VALU_SH64_W;
		endcase
	endfunction

	function automatic logic [63:0] rand_dword();
		return {$urandom, $urandom};
	endfunction

	// A 1 in the low bit of every lane, marked by the last byte of each lane
	function automatic logic [63:0] lane_ones(input valu_pkg::width_t w);
		valu_pkg::lane_carry_t last;
		logic [63:0]           v;
		v = '0;
		for (int i = 0; i < `VALU_NBYTES; i++) begin
			last[i] = ((i + 1) % (lane_bits(w) / 8)) == 0;
			if (last[i]) begin
				v = v | (64'd1 << ((`VALU_NBYTES - 1 - i) * 8));
			end
		end
		return v;
	endfunction

	function automatic logic [63:0] lane_msbs(input valu_pkg::width_t w);
		return lane_ones(w) << (lane_bits(w) - 1);
	endfunction

	// Lane i counts from the left, so it sits (n-1-i) lanes above bit 0 of a [63:0] word
	function automatic logic [63:0] expected_value(input valu_pkg::major_op_t op,
			input valu_pkg::func_t f, input valu_pkg::width_t w,
			input logic [63:0] a, input logic [63:0] b);
		int          lw;
		int          n;
		int          amt;
		int          lane;
		logic [63:0] mask;
		logic [63:0] la;
		logic [63:0] lb;
		logic [63:0] r;
		logic [63:0] res;
		lw = lane_bits(w);
		n = `VALU_DW / lw;
		mask = {64{1'b1}} >> (64 - lw);
		res = '0;
		if (op != valu_pkg::R_ALU) begin
			res = '0;
		end else if (f == valu_pkg::VMULEU || f == valu_pkg::VMULOU) begin
			// No lane pair at W64, so the loop is empty there
			for (int p = 0; p < n / 2; p++) begin
				lane = 2 * p + ((f == valu_pkg::VMULOU) ? 1 : 0);
				la = (a >> ((n - 1 - lane) * lw)) & mask;
				lb = (b >> ((n - 1 - lane) * lw)) & mask;
				res = res | ((la * lb) << ((n / 2 - 1 - p) * 2 * lw));
			end
		end else begin
			for (int i = 0; i < n; i++) begin
				la = (a >> ((n - 1 - i) * lw)) & mask;
				lb = (b >> ((n - 1 - i) * lw)) & mask;
				amt = int'(lb) & ((1 << amount_bits(w)) - 1);
				case (f)
					valu_pkg::VAND:  r = la & lb;
					valu_pkg::VOR:   r = la | lb;
					valu_pkg::VXOR:  r = la ^ lb;
					valu_pkg::VNOT:  r = ~la & mask;
					valu_pkg::VMOV:  r = la;
					valu_pkg::VRTTH: r = ((la << (lw / 2)) | (la >> (lw / 2))) & mask;
					valu_pkg::VADD:  r = (la + lb) & mask;
					valu_pkg::VSUB:  r = (la - lb) & mask;
					valu_pkg::VSLL:  r = (la << amt) & mask;
					valu_pkg::VSRL:  r = la >> amt;
					valu_pkg::VSRA: begin
						r = la >> amt;
						if (la[lw-1]) begin
							r = r | (mask & ~(mask >> amt));
						end
					end
					default:         r = '0;
				endcase
				res = res | (r << ((n - 1 - i) * lw));
			end
		end
		return res;
	endfunction

	task automatic compare(input string sig, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %0t ns %s %s: expected %h, got %h", $time, test_name, sig, exp, act);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after the idle check
	task automatic issue_and_check(input valu_pkg::major_op_t op, input valu_pkg::func_t f,
			input valu_pkg::width_t w, input logic [63:0] a, input logic [63:0] b);
		logic [63:0] exp;
		int          waited;
		exp = expected_value(op, f, w, a, b);
		op_code = op;
		r_ins = f;
		ww = w;
		ra = a;
		rb = b;
		issue = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		// New operands while idle must not disturb the held result
		ra = ~a;
		rb = ~b;
		waited = 0;
		while (!result_valid && waited < VALID_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!result_valid) begin
			errors++;
			$display("%s: result_valid never came within %0d cycles", test_name, VALID_TIMEOUT);
		end else begin
			compare("result", exp, result);
		end
		@(negedge clk);
		compare("result_valid", 64'd0, 64'(result_valid));
		compare("result", exp, result);
	endtask

	task automatic bitwise_test();
		logic [63:0]      a;
		logic [63:0]      b;
		valu_pkg::width_t w;
		int               start;
		test_name = "bitwise";
		start = errors;
		for (int rep = 0; rep < 3; rep++) begin
			a = rand_dword();
			b = rand_dword();
			w = valu_pkg::width_t'(2'($urandom % 4));
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VAND, w, a, b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VOR, w, a, b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VXOR, w, a, b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VNOT, w, a, b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VMOV, w, a, b);
			for (int k = 0; k < 4; k++) begin
				issue_and_check(valu_pkg::R_ALU, valu_pkg::VRTTH, valu_pkg::width_t'(k[1:0]), a, b);
			end
		end
		$display("%s done, %0d errors", test_name, errors - start);
	endtask

	task automatic addsub_test();
		valu_pkg::width_t w;
		int               start;
		test_name = "addsub";
		start = errors;
		for (int k = 0; k < 4; k++) begin
			w = valu_pkg::width_t'(k[1:0]);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VADD, w, rand_dword(), rand_dword());
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSUB, w, rand_dword(), rand_dword());
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VADD, w, {64{1'b1}}, lane_ones(w));
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSUB, w, 64'd0, lane_ones(w));
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VADD, w, lane_msbs(w), lane_msbs(w));
		end
		$display("%s done, %0d errors", test_name, errors - start);
	endtask

	task automatic shift_test();
		valu_pkg::width_t w;
		logic [63:0]      a;
		logic [63:0]      b;
		int               start;
		test_name = "shift";
		start = errors;
		for (int k = 0; k < 4; k++) begin
			w = valu_pkg::width_t'(k[1:0]);
			a = rand_dword();
			b = rand_dword();
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSLL, w, a, b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSRL, w, a, b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSRA, w, a, b);
			// Every lane negative
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSRA, w, a | lane_msbs(w), b);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VSRA, w, lane_msbs(w), {64{1'b1}});
		end
		$display("%s done, %0d errors", test_name, errors - start);
	endtask

	task automatic mult_test();
		valu_pkg::width_t w;
		int               start;
		test_name = "mult";
		start = errors;
		for (int k = 0; k < 4; k++) begin
			w = valu_pkg::width_t'(k[1:0]);
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VMULEU, w, rand_dword(), rand_dword());
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VMULOU, w, rand_dword(), rand_dword());
			issue_and_check(valu_pkg::R_ALU, valu_pkg::VMULOU, w, {64{1'b1}}, {64{1'b1}});
		end
		$display("%s done, %0d errors", test_name, errors - start);
	endtask

	task automatic illegal_test();
		int start;
		test_name = "illegal";
		start = errors;
		// Load a nonzero result first so a zero is visible
		issue_and_check(valu_pkg::R_ALU, valu_pkg::VMOV, valu_pkg::W64, {64{1'b1}}, 64'd0);
		issue_and_check(valu_pkg::major_op_t'(6'b000000), valu_pkg::VADD, valu_pkg::W8,
			rand_dword(), rand_dword());
		issue_and_check(valu_pkg::R_ALU, valu_pkg::VMOV, valu_pkg::W64, {64{1'b1}}, 64'd0);
		issue_and_check(valu_pkg::R_ALU, valu_pkg::func_t'(6'h3f), valu_pkg::W8,
			rand_dword(), rand_dword());
		issue_and_check(valu_pkg::R_ALU, valu_pkg::VNOP, valu_pkg::W16, rand_dword(), 64'd1);
		$display("%s done, %0d errors", test_name, errors - start);
	endtask

	task automatic pipeline_test();
		valu_pkg::func_t  fs [0:3];
		valu_pkg::width_t ws [0:3];
		logic [63:0]      opa [0:3];
		logic [63:0]      opb [0:3];
		logic [63:0]      exp [0:3];
		int               start;
		test_name = "pipeline";
		start = errors;
		fs[0] = valu_pkg::VADD;
		ws[0] = valu_pkg::W8;
		fs[1] = valu_pkg::VSUB;
		ws[1] = valu_pkg::W16;
		fs[2] = valu_pkg::VSRA;
		ws[2] = valu_pkg::W32;
		fs[3] = valu_pkg::VMULOU;
		ws[3] = valu_pkg::W16;
		for (int k = 0; k < 4; k++) begin
			opa[k] = rand_dword();
			opb[k] = rand_dword();
			exp[k] = expected_value(valu_pkg::R_ALU, fs[k], ws[k], opa[k], opb[k]);
		end
		// One issue per cycle, each result checked on the next falling edge
		for (int k = 0; k <= 4; k++) begin
			if (k > 0) begin
				compare("result_valid", 64'd1, 64'(result_valid));
				compare("result", exp[k-1], result);
			end
			if (k < 4) begin
				op_code = valu_pkg::R_ALU;
				r_ins = fs[k];
				ww = ws[k];
				ra = opa[k];
				rb = opb[k];
				issue = 1'b1;
			end else begin
				issue = 1'b0;
				ra = ~opa[3];
				rb = ~opb[3];
			end
			@(negedge clk);
		end
		compare("result_valid", 64'd0, 64'(result_valid));
		compare("result", exp[3], result);
		$display("%s done, %0d errors", test_name, errors - start);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		// An issue during reset must not reach the outputs
		issue = 1'b1;
		op_code = valu_pkg::R_ALU;
		r_ins = valu_pkg::VMOV;
		ww = valu_pkg::W64;
		ra = {64{1'b1}};
		rb = '0;
		checks = 0;
		errors = 0;
		test_name = "reset";
		void'($urandom(15624));
		repeat (3) @(posedge clk);
		@(negedge clk);
		issue = 1'b0;
		@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		compare("result_valid", 64'd0, 64'(result_valid));
		compare("result", 64'd0, result);
		$display("%s done, %0d errors", test_name, errors);
		bitwise_test();
		addsub_test();
		shift_test();
		mult_test();
		illegal_test();
		pipeline_test();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- valu.f
+incdir+.
valu_pkg.sv
valu_bitwise.sv
valu_addsub.sv
valu_shifter.sv
valu_mult.sv
valu_result_stage.sv
valu_top.sv
valu_sva.sv
valu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the valu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module valu_tb -f valu.f -o valu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/valu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0
